// File: tb.f
+incdir+include
rtl/rs_ring_pkg.sv
rtl/uop_dispatch_stage.sv
rtl/ring_slot.sv
rtl/rs_ring_top.sv
tb/rs_ring_tb.sv

// File: Bender.yml
package:
  name: rs_ring

export_include_dirs:
  - include

sources:
  - rtl/rs_ring_pkg.sv
  - rtl/uop_dispatch_stage.sv
  - rtl/ring_slot.sv
  - rtl/rs_ring_top.sv
  - target: test
    files:
      - tb/rs_ring_tb.sv

// File: tb/rs_ring_tb.sv
`timescale 1ns/1ps
`include "rs_ring_cfg.svh"

module rs_ring_tb;

    localparam int NUM_UNITS    = `RS_NUM_UNITS;
    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 12;
    localparam int SINGLE_GAP   = 10;    // Idle cycles after each single micro-op
    localparam int BURST_CYCLES = 400;
    localparam int ILLEGAL_CYCLES = 150;
    localparam int HOLD_CYCLES  = 200;
    localparam int DRAIN_CYCLES = 10;    // Longer than the deepest ring latency
    localparam int MARGIN       = 100;
    localparam int WATCHDOG_CYCLES = 2 + RESET_CYCLES + 5 * (1 + SINGLE_GAP) + BURST_CYCLES
                                   + ILLEGAL_CYCLES + HOLD_CYCLES + 5 * DRAIN_CYCLES + MARGIN;
    localparam logic [31:0] SEED = 32'h8520_9547;

    typedef struct {
        int                    due;
        rs_ring_pkg::rob_idx_t rob_entry;
        rs_ring_pkg::xlen_t    pc;
        rs_ring_pkg::opcode_t  opcode;
        rs_ring_pkg::op_type_t opcode_type;
        rs_ring_pkg::xlen_t    rs1_value;
        rs_ring_pkg::xlen_t    rs2_value;
    } exp_t;

    logic                  clk;
    logic                  rst_n;
    logic                  valid_in;
    rs_ring_pkg::fu_e      uop_unit;
    rs_ring_pkg::rob_idx_t uop_rob_entry;
    rs_ring_pkg::xlen_t    uop_pc;
    rs_ring_pkg::opcode_t  uop_opcode;
    rs_ring_pkg::op_type_t uop_opcode_type;
    rs_ring_pkg::xlen_t    uop_rs1_value;
    rs_ring_pkg::xlen_t    uop_rs2_value;

    logic                  issue_valid       [NUM_UNITS];
    rs_ring_pkg::rob_idx_t issue_rob_entry   [NUM_UNITS];
    rs_ring_pkg::xlen_t    issue_pc          [NUM_UNITS];
    rs_ring_pkg::opcode_t  issue_opcode      [NUM_UNITS];
    rs_ring_pkg::op_type_t issue_opcode_type [NUM_UNITS];
    rs_ring_pkg::xlen_t    issue_rs1_value   [NUM_UNITS];
    rs_ring_pkg::xlen_t    issue_rs2_value   [NUM_UNITS];

    exp_t        exp_q [NUM_UNITS][$];   // Pending issues per ring position
    exp_t        last_issue  [NUM_UNITS];
    logic        have_issued [NUM_UNITS];
    logic [31:0] rng_state;
    int          edge_cnt;
    int          err_count;
    int          check_count;
    int          tests_passed;
    int          tests_failed;
    int          test_err_base;

    rs_ring_top dut (
        .clk               (clk),
        .rst_n             (rst_n),
        .valid_in          (valid_in),
        .uop_unit          (uop_unit),
        .uop_rob_entry     (uop_rob_entry),
        .uop_pc            (uop_pc),
        .uop_opcode        (uop_opcode),
        .uop_opcode_type   (uop_opcode_type),
        .uop_rs1_value     (uop_rs1_value),
        .uop_rs2_value     (uop_rs2_value),
        .issue_valid       (issue_valid),
        .issue_rob_entry   (issue_rob_entry),
        .issue_pc          (issue_pc),
        .issue_opcode      (issue_opcode),
        .issue_opcode_type (issue_opcode_type),
        .issue_rs1_value   (issue_rs1_value),
        .issue_rs2_value   (issue_rs2_value)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    // ***********************************************************
    // Model helpers
    // ***********************************************************

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic unit_is_legal(input logic [2:0] unit);
        return (unit >= 3'd1) && (unit <= 3'd5);
    endfunction

    // Ring order is arith, logical, branch, mul_div, ld_st
    function automatic int ring_position(input logic [2:0] unit);
        case (unit)
            3'd2:    return 0;
            3'd1:    return 1;
            3'd3:    return 2;
            3'd4:    return 3;
            3'd5:    return 4;
            default: return -1;
        endcase
    endfunction

    task automatic report_mismatch(input string sig, input int p, input logic [31:0] got,
                                   input logic [31:0] exp);
        err_count++;
        $display("[FAIL] %s[%0d] got 0x%h expected 0x%h at cycle %0d",
                 sig, p, got, exp, edge_cnt);
    endtask

    task automatic compare_payload(input int p, input exp_t e);
        if (issue_rob_entry[p] !== e.rob_entry)
            report_mismatch("issue_rob_entry", p, 32'(issue_rob_entry[p]), 32'(e.rob_entry));
        if (issue_pc[p] !== e.pc)
            report_mismatch("issue_pc", p, issue_pc[p], e.pc);
        if (issue_opcode[p] !== e.opcode)
            report_mismatch("issue_opcode", p, 32'(issue_opcode[p]), 32'(e.opcode));
        if (issue_opcode_type[p] !== e.opcode_type)
            report_mismatch("issue_opcode_type", p, 32'(issue_opcode_type[p]),
                            32'(e.opcode_type));
        if (issue_rs1_value[p] !== e.rs1_value)
            report_mismatch("issue_rs1_value", p, issue_rs1_value[p], e.rs1_value);
        if (issue_rs2_value[p] !== e.rs2_value)
            report_mismatch("issue_rs2_value", p, issue_rs2_value[p], e.rs2_value);
    endtask

    // Compares every unit's outputs against the model for this cycle
    task automatic check_outputs();
        exp_t e;
        logic due;
        for (int p = 0; p < NUM_UNITS; p++) begin
            due = (exp_q[p].size() != 0) && (exp_q[p][0].due == edge_cnt);
            if (issue_valid[p] !== due)
                report_mismatch("issue_valid", p, 32'(issue_valid[p]), 32'(due));
            if (due) begin
                e = exp_q[p].pop_front();
                if (issue_valid[p] === 1'b1) begin
                    compare_payload(p, e);
                    last_issue[p]  = e;
                    have_issued[p] = 1'b1;
                end
            end else if (have_issued[p] && issue_valid[p] !== 1'b1) begin
                compare_payload(p, last_issue[p]);    // Data must hold between issues
            end
        end
        check_count++;
    endtask

    // One cycle: check outputs, then drive the next input 1 ns after the edge
    task automatic drive_cycle(input logic valid, input logic [2:0] unit);
        logic [31:0] r;
        exp_t        e;
        int          pos;
        @(posedge clk);
        #1;
        check_outputs();
        r               = next_random();
        valid_in        = valid;
        uop_unit        = rs_ring_pkg::fu_e'(unit);
        uop_rob_entry   = rs_ring_pkg::rob_idx_t'(r);
        uop_opcode      = rs_ring_pkg::opcode_t'(r >> 8);
        uop_opcode_type = rs_ring_pkg::op_type_t'(r >> 13);
        uop_pc          = next_random();
        uop_rs1_value   = next_random();
        uop_rs2_value   = next_random();
        pos             = ring_position(unit);
        if (valid && unit_is_legal(unit)) begin
            e.due         = edge_cnt + 3 + pos;    // Dispatch edge + 2 + ring position
            e.rob_entry   = uop_rob_entry;
            e.pc          = uop_pc;
            e.opcode      = uop_opcode;
            e.opcode_type = uop_opcode_type;
            e.rs1_value   = uop_rs1_value;
            e.rs2_value   = uop_rs2_value;
            exp_q[pos].push_back(e);
        end
    endtask

    function automatic logic [2:0] random_legal_unit();
        return 3'(1 + (next_random() % 5));
    endfunction

    task automatic drain();
        repeat (DRAIN_CYCLES) drive_cycle(1'b0, 3'd0);
    endtask

    task automatic start_test();
        test_err_base = err_count;
    endtask

    task automatic end_test(input string name);
        for (int p = 0; p < NUM_UNITS; p++) begin
            if (exp_q[p].size() != 0) begin
                err_count++;
                $display("Ring position %0d still waits for %0d issues after %s",
                         p, exp_q[p].size(), name);
                exp_q[p].delete();
            end
        end
        if (err_count == test_err_base) begin
            tests_passed++;
            $display("test %-12s ok", name);
        end else begin
            tests_failed++;
            $display("test %-12s %0d errors", name, err_count - test_err_base);
        end
    endtask

    // ***********************************************************
    // Test sequence
    // ***********************************************************

    initial begin
        logic [31:0] r;
        clk             = 1'b0;
        rst_n           = 1'b0;
        valid_in        = 1'b0;
        uop_unit        = rs_ring_pkg::FU_NONE;
        uop_rob_entry   = '0;
        uop_pc          = '0;
        uop_opcode      = '0;
        uop_opcode_type = '0;
        uop_rs1_value   = '0;
        uop_rs2_value   = '0;
        rng_state       = SEED;
        edge_cnt        = 0;
        err_count       = 0;
        check_count     = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        for (int p = 0; p < NUM_UNITS; p++) have_issued[p] = 1'b0;

        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        start_test();
        repeat (RESET_CYCLES) drive_cycle(1'b0, random_legal_unit());
        end_test("reset");

        start_test();
        for (int u = 1; u <= 5; u++) begin
            drive_cycle(1'b1, 3'(u));
            repeat (SINGLE_GAP) drive_cycle(1'b0, 3'd0);
        end
        end_test("single");

        start_test();
        repeat (BURST_CYCLES) drive_cycle(1'b1, random_legal_unit());
        drain();
        end_test("burst");

        start_test();
        repeat (ILLEGAL_CYCLES) begin
            r = next_random();
            case (r[1:0])
                2'd0:    drive_cycle(1'b1, 3'd0);
                2'd1:    drive_cycle(1'b1, 3'd6);
                2'd2:    drive_cycle(1'b1, 3'd7);
                default: drive_cycle(1'b0, random_legal_unit());
            endcase
        end
        drain();
        end_test("illegal");

        // Sparse traffic leaves idle gaps where issue data must hold
        start_test();
        repeat (HOLD_CYCLES) begin
            r = next_random();
            drive_cycle(r[1:0] == 2'd0, random_legal_unit());
        end
        drain();
        end_test("hold");

        $display("tests passed %0d failed %0d, %0d cycles checked, %0d errors",
                 tests_passed, tests_failed, check_count, err_count);
        if (err_count == 0 && tests_failed == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
        $display("sim failed");
        $finish;
    end

endmodule

// File: rtl/rs_ring_top.sv
`timescale 1ns/1ps
`include "rs_ring_cfg.svh"

module rs_ring_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  valid_in,
    input  rs_ring_pkg::fu_e      uop_unit,
    input  rs_ring_pkg::rob_idx_t uop_rob_entry,
    input  rs_ring_pkg::xlen_t    uop_pc,
    input  rs_ring_pkg::opcode_t  uop_opcode,
    input  rs_ring_pkg::op_type_t uop_opcode_type,
    input  rs_ring_pkg::xlen_t    uop_rs1_value,
    input  rs_ring_pkg::xlen_t    uop_rs2_value,

    // Indexed by ring position
    output logic                  issue_valid       [`RS_NUM_UNITS],
    output rs_ring_pkg::rob_idx_t issue_rob_entry   [`RS_NUM_UNITS],
    output rs_ring_pkg::xlen_t    issue_pc          [`RS_NUM_UNITS],
    output rs_ring_pkg::opcode_t  issue_opcode      [`RS_NUM_UNITS],
    output rs_ring_pkg::op_type_t issue_opcode_type [`RS_NUM_UNITS],
    output rs_ring_pkg::xlen_t    issue_rs1_value   [`RS_NUM_UNITS],
    output rs_ring_pkg::xlen_t    issue_rs2_value   [`RS_NUM_UNITS]
);

    localparam int NUM_UNITS = `RS_NUM_UNITS;

    // Unit served at each ring position
    localparam rs_ring_pkg::fu_e RING_ORDER [NUM_UNITS] = '{
        rs_ring_pkg::FU_ARITH,
        rs_ring_pkg::FU_LOGICAL,
        rs_ring_pkg::FU_BRANCH,
        rs_ring_pkg::FU_MUL_DIV,
        rs_ring_pkg::FU_LD_ST
    };

    // Element g feeds the slot at ring position g
    logic                  ring_valid       [NUM_UNITS];
    rs_ring_pkg::fu_e      ring_unit        [NUM_UNITS];
    rs_ring_pkg::rob_idx_t ring_rob_entry   [NUM_UNITS];
    rs_ring_pkg::xlen_t    ring_pc          [NUM_UNITS];
    rs_ring_pkg::opcode_t  ring_opcode      [NUM_UNITS];
    rs_ring_pkg::op_type_t ring_opcode_type [NUM_UNITS];
    rs_ring_pkg::xlen_t    ring_rs1_value   [NUM_UNITS];
    rs_ring_pkg::xlen_t    ring_rs2_value   [NUM_UNITS];

    uop_dispatch_stage u_dispatch (
        .clk              (clk),
        .rst_n            (rst_n),
        .valid_in         (valid_in),
        .uop_unit         (uop_unit),
        .uop_rob_entry    (uop_rob_entry),
        .uop_pc           (uop_pc),
        .uop_opcode       (uop_opcode),
        .uop_opcode_type  (uop_opcode_type),
        .uop_rs1_value    (uop_rs1_value),
        .uop_rs2_value    (uop_rs2_value),
        .slot_valid       (ring_valid[0]),
        .slot_unit        (ring_unit[0]),
        .slot_rob_entry   (ring_rob_entry[0]),
        .slot_pc          (ring_pc[0]),
        .slot_opcode      (ring_opcode[0]),
        .slot_opcode_type (ring_opcode_type[0]),
        .slot_rs1_value   (ring_rs1_value[0]),
        .slot_rs2_value   (ring_rs2_value[0])
    );

    // ***********************************************************
    // Ring of slots
    // ***********************************************************

    for (genvar g = 0; g < NUM_UNITS; g++) begin : g_slot
        if (g < NUM_UNITS - 1) begin : g_mid
            ring_slot #(.SLOT_UNIT(RING_ORDER[g])) u_slot (
                .clk (clk), .rst_n (rst_n),
                .in_valid          (ring_valid[g]),
                .in_unit           (ring_unit[g]),
                .in_rob_entry      (ring_rob_entry[g]),
                .in_pc             (ring_pc[g]),
                .in_opcode         (ring_opcode[g]),
                .in_opcode_type    (ring_opcode_type[g]),
                .in_rs1_value      (ring_rs1_value[g]),
                .in_rs2_value      (ring_rs2_value[g]),
                .out_valid         (ring_valid[g+1]),
                .out_unit          (ring_unit[g+1]),
                .out_rob_entry     (ring_rob_entry[g+1]),
                .out_pc            (ring_pc[g+1]),
                .out_opcode        (ring_opcode[g+1]),
                .out_opcode_type   (ring_opcode_type[g+1]),
                .out_rs1_value     (ring_rs1_value[g+1]),
                .out_rs2_value     (ring_rs2_value[g+1]),
                .issue_valid       (issue_valid[g]),
                .issue_rob_entry   (issue_rob_entry[g]),
                .issue_pc          (issue_pc[g]),
                .issue_opcode      (issue_opcode[g]),
                .issue_opcode_type (issue_opcode_type[g]),
                .issue_rs1_value   (issue_rs1_value[g]),
                .issue_rs2_value   (issue_rs2_value[g])
            );
        end else begin : g_last
            // Micro-ops leave the ring after the ld_st slot
            ring_slot #(.SLOT_UNIT(RING_ORDER[g])) u_slot (
                .clk (clk), .rst_n (rst_n),
                .in_valid          (ring_valid[g]),
                .in_unit           (ring_unit[g]),
                .in_rob_entry      (ring_rob_entry[g]),
                .in_pc             (ring_pc[g]),
                .in_opcode         (ring_opcode[g]),
                .in_opcode_type    (ring_opcode_type[g]),
                .in_rs1_value      (ring_rs1_value[g]),
                .in_rs2_value      (ring_rs2_value[g]),
                .out_valid         (),
                .out_unit          (),
                .out_rob_entry     (),
                .out_pc            (),
                .out_opcode        (),
                .out_opcode_type   (),
                .out_rs1_value     (),
                .out_rs2_value     (),
                .issue_valid       (issue_valid[g]),
                .issue_rob_entry   (issue_rob_entry[g]),
                .issue_pc          (issue_pc[g]),
                .issue_opcode      (issue_opcode[g]),
                .issue_opcode_type (issue_opcode_type[g]),
                .issue_rs1_value   (issue_rs1_value[g]),
                .issue_rs2_value   (issue_rs2_value[g])
            );
        end
    end

endmodule

// File: rtl/ring_slot.sv
`timescale 1ns/1ps

module ring_slot #(
    parameter rs_ring_pkg::fu_e SLOT_UNIT = rs_ring_pkg::FU_ARITH
) (
    input  logic                  clk,
    input  logic                  rst_n,

    // From the previous slot
    input  logic                  in_valid,
    input  rs_ring_pkg::fu_e      in_unit,
    input  rs_ring_pkg::rob_idx_t in_rob_entry,
    input  rs_ring_pkg::xlen_t    in_pc,
    input  rs_ring_pkg::opcode_t  in_opcode,
    input  rs_ring_pkg::op_type_t in_opcode_type,
    input  rs_ring_pkg::xlen_t    in_rs1_value,
    input  rs_ring_pkg::xlen_t    in_rs2_value,

    // To the next slot
    output logic                  out_valid,
    output rs_ring_pkg::fu_e      out_unit,
    output rs_ring_pkg::rob_idx_t out_rob_entry,
    output rs_ring_pkg::xlen_t    out_pc,
    output rs_ring_pkg::opcode_t  out_opcode,
    output rs_ring_pkg::op_type_t out_opcode_type,
    output rs_ring_pkg::xlen_t    out_rs1_value,
    output rs_ring_pkg::xlen_t    out_rs2_value,

    // To this slot's functional unit
    output logic                  issue_valid,
    output rs_ring_pkg::rob_idx_t issue_rob_entry,
    output rs_ring_pkg::xlen_t    issue_pc,
    output rs_ring_pkg::opcode_t  issue_opcode,
    output rs_ring_pkg::op_type_t issue_opcode_type,
    output rs_ring_pkg::xlen_t    issue_rs1_value,
    output rs_ring_pkg::xlen_t    issue_rs2_value
);

    logic hit;

    assign hit = out_valid && (out_unit == SLOT_UNIT);   // Held uop belongs here

    // ***********************************************************
    // Ring stage
    // ***********************************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // Ring advances every cycle, no stall
    always_ff @(posedge clk) begin
        out_unit        <= in_unit;
        out_rob_entry   <= in_rob_entry;
        out_pc          <= in_pc;
        out_opcode      <= in_opcode;
        out_opcode_type <= in_opcode_type;
        out_rs1_value   <= in_rs1_value;
        out_rs2_value   <= in_rs2_value;
    end

    // ***********************************************************
    // Issue capture
    // ***********************************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= hit;                           // One-cycle strobe
        end
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            issue_rob_entry   <= out_rob_entry;
            issue_pc          <= out_pc;
            issue_opcode      <= out_opcode;
            issue_opcode_type <= out_opcode_type;
            issue_rs1_value   <= out_rs1_value;
            issue_rs2_value   <= out_rs2_value;
        end
    end

    // ***********************************************************
    // Checks
    // ***********************************************************

    a_issue_after_match : assert property (
        @(posedge clk) disable iff (!rst_n)
        issue_valid |-> $past(out_valid) && ($past(out_unit) == SLOT_UNIT)
    ) else $error("unit %0d issued without a matching slot", SLOT_UNIT);

    a_issue_pulse : assert property (
        @(posedge clk) disable iff (!rst_n)
        (issue_valid && $past(issue_valid)) |-> $past(hit) && $past(hit, 2)
    ) else $error("unit %0d issue_valid held without back-to-back matches", SLOT_UNIT);

endmodule

// File: rtl/uop_dispatch_stage.sv
`timescale 1ns/1ps

module uop_dispatch_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  valid_in,
    input  rs_ring_pkg::fu_e      uop_unit,
    input  rs_ring_pkg::rob_idx_t uop_rob_entry,
    input  rs_ring_pkg::xlen_t    uop_pc,
    input  rs_ring_pkg::opcode_t  uop_opcode,
    input  rs_ring_pkg::op_type_t uop_opcode_type,
    input  rs_ring_pkg::xlen_t    uop_rs1_value,
    input  rs_ring_pkg::xlen_t    uop_rs2_value,
    output logic                  slot_valid,
    output rs_ring_pkg::fu_e      slot_unit,
    output rs_ring_pkg::rob_idx_t slot_rob_entry,
    output rs_ring_pkg::xlen_t    slot_pc,
    output rs_ring_pkg::opcode_t  slot_opcode,
    output rs_ring_pkg::op_type_t slot_opcode_type,
    output rs_ring_pkg::xlen_t    slot_rs1_value,
    output rs_ring_pkg::xlen_t    slot_rs2_value
);

    logic accept;

    // Illegal unit codes are dropped here and never reach the ring
    assign accept = valid_in && rs_ring_pkg::fu_is_legal(uop_unit);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_valid <= 1'b0;
        end else begin
            slot_valid <= accept;
        end
    end

    // Payload only moves on an accepted micro-op
    always_ff @(posedge clk) begin
        if (accept) begin
            slot_unit        <= uop_unit;
            slot_rob_entry   <= uop_rob_entry;
            slot_pc          <= uop_pc;
            slot_opcode      <= uop_opcode;
            slot_opcode_type <= uop_opcode_type;
            slot_rs1_value   <= uop_rs1_value;
            slot_rs2_value   <= uop_rs2_value;
        end
    end

    // ***********************************************************
    // Checks
    // ***********************************************************

    a_slot_unit_legal : assert property (
        @(posedge clk) disable iff (!rst_n)
        slot_valid |-> (slot_unit != rs_ring_pkg::FU_NONE) &&
                       (slot_unit <= rs_ring_pkg::FU_LD_ST)
    ) else $error("dispatch slot valid with illegal unit %0d", slot_unit);

endmodule

// File: rtl/rs_ring_pkg.sv
`include "rs_ring_cfg.svh"

package rs_ring_pkg;

    // ***********************************************************
    // Micro-op field types
    // ***********************************************************

    typedef logic [`RS_XLEN-1:0]              xlen_t;     // Operand value and PC
    typedef logic [$clog2(`RS_ROB_SIZE)-1:0]  rob_idx_t;
    typedef logic [`RS_OPCODE_W-1:0]          opcode_t;
    typedef logic [`RS_OPTYPE_W-1:0]          op_type_t;

    // ***********************************************************
    // Functional units
    // ***********************************************************

    // Codes 6 and 7 are unused and treated like FU_NONE
    typedef enum logic [2:0] {
        FU_NONE    = 3'd0,
        FU_LOGICAL = 3'd1,
        FU_ARITH   = 3'd2,
        FU_BRANCH  = 3'd3,
        FU_MUL_DIV = 3'd4,
        FU_LD_ST   = 3'd5
    } fu_e;

    // True for the five codes that name a real unit
    function automatic logic fu_is_legal(input fu_e unit);
        logic legal;
        legal = (unit != FU_NONE) && (unit <= FU_LD_ST);
        return legal;
    endfunction

endpackage

// File: include/rs_ring_cfg.svh
`ifndef RS_RING_CFG_SVH
`define RS_RING_CFG_SVH

// ***********************************************************
// Datapath widths
// ***********************************************************

`define RS_XLEN        32    // Operand and PC width
`define RS_ROB_SIZE    256   // ROB entries, sets rob index width

// ***********************************************************
// Ring geometry and micro-op fields
// ***********************************************************

`define RS_NUM_UNITS   5     // Slots on the ring, one per unit
`define RS_OPCODE_W    5
`define RS_OPTYPE_W    3

`endif
